// File: hw/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath and address widths
`define RV_XLEN     32
`define RV_REG_AW   5
`define RV_DMEM_AW  8            // word address, 256 words of data memory

// major opcodes the pipeline keeps, anything else is a bubble
`define RV_OP_OP    7'b011_0011  // register-register alu
`define RV_OP_IMM   7'b001_0011  // register-immediate alu
`define RV_OP_LOAD  7'b000_0011
`define RV_OP_STORE 7'b010_0011

// funct3 for OP and OP-IMM
`define RV_F3_ADD   3'b000       // ADD, SUB, ADDI
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101       // SRL, SRA and immediate forms
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// funct3 for loads and stores
`define RV_F3_LB    3'b000
`define RV_F3_LH    3'b001
`define RV_F3_LW    3'b010
`define RV_F3_LBU   3'b100
`define RV_F3_LHU   3'b101
`define RV_F3_SB    3'b000
`define RV_F3_SH    3'b001
`define RV_F3_SW    3'b010

// funct7, plain and with bit 30 set for SUB and SRA
`define RV_F7_BASE  7'b000_0000
`define RV_F7_ALT   7'b010_0000

`endif

// File: hw/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    // R format, register-register alu
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    // I format, op-imm and loads
    typedef struct packed {
        logic [11:0]           imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } instr_i_t;

    // S format, immediate split around rs2
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } instr_s_t;

    // one fetched word, viewed by whichever format the opcode selects
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NOP, MEM_LOAD, MEM_STORE
    } mem_op_e;

    // codes equal the load/store funct3, stores use the signed names
    typedef enum logic [2:0] {
        BYTE_S = 3'b000, HALF_S = 3'b001, WORD = 3'b010, BYTE_U = 3'b100, HALF_U = 3'b101
    } mem_width_e;

endpackage

// File: hw/rv_regfile.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  wr_en,
    input  logic [`RV_REG_AW-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]   wr_data
);

    localparam int NREG = 1 << `RV_REG_AW;

    logic [`RV_XLEN-1:0] regs [1:NREG-1];      // x0 has no storage

    // combinational reads, x0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;           // write-back stage, end of its cycle
        end
    end

endmodule

// File: hw/rv_forward.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_forward (
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]   rs1_data,    // regfile values
    input  logic [`RV_XLEN-1:0]   rs2_data,
    input  logic [`RV_REG_AW-1:0] ex_rd,       // one back
    input  logic                  ex_wb_en,
    input  logic                  ex_is_load,
    input  logic [`RV_XLEN-1:0]   alu_out,
    input  logic [`RV_REG_AW-1:0] mem_rd,      // two back
    input  logic                  mem_wb_en,
    input  logic                  mem_is_load,
    input  logic [`RV_XLEN-1:0]   mem_alu_res,
    input  logic [`RV_REG_AW-1:0] wb_rd,       // three back
    input  logic                  wb_en,
    input  logic [`RV_XLEN-1:0]   wb_data,
    output logic [`RV_XLEN-1:0]   rs1_val,
    output logic [`RV_XLEN-1:0]   rs2_val
);

    // youngest producer first, loads only usable once in write-back
    function automatic logic [`RV_XLEN-1:0] pick(input logic [`RV_REG_AW-1:0] src,
                                                 input logic [`RV_XLEN-1:0]   rf_val);
        if (src == '0)
            return rf_val;                                      // x0 never forwarded
        if (ex_wb_en && !ex_is_load && ex_rd == src)
            return alu_out;
        if (mem_wb_en && !mem_is_load && mem_rd == src)
            return mem_alu_res;
        if (wb_en && wb_rd == src)
            return wb_data;                                     // alu result or load data
        return rf_val;
    endfunction

    always_comb begin
        rs1_val = pick(rs1_addr, rs1_data);
        rs2_val = pick(rs2_addr, rs2_data);
    end

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_alu (
    input  rv_pkg::alu_op_e     alu_op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] y
);

    localparam int SHW = $clog2(`RV_XLEN);      // shift amount width

    logic [SHW-1:0] shamt;

    assign shamt = b[SHW-1:0];

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD:  y = a + b;
            rv_pkg::ALU_SUB:  y = a - b;
            rv_pkg::ALU_SLL:  y = a << shamt;
            rv_pkg::ALU_SLT:  y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: y = {{(`RV_XLEN-1){1'b0}}, a < b};
            rv_pkg::ALU_XOR:  y = a ^ b;
            rv_pkg::ALU_SRL:  y = a >> shamt;
            rv_pkg::ALU_SRA:  y = $unsigned($signed(a) >>> shamt);  // sign fills from the top
            rv_pkg::ALU_OR:   y = a | b;
            rv_pkg::ALU_AND:  y = a & b;
            default:          y = '0;                               // bubble
        endcase
    end

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_pkg::instr_u        instr,
    input  logic [`RV_XLEN-1:0]   rs1_val,        // operands after forwarding
    input  logic [`RV_XLEN-1:0]   rs2_val,
    output logic [`RV_REG_AW-1:0] rs1_addr,       // regfile read ports
    output logic [`RV_REG_AW-1:0] rs2_addr,
    output rv_pkg::alu_op_e       ex_alu_op,
    output logic [`RV_XLEN-1:0]   ex_alu_a,
    output logic [`RV_XLEN-1:0]   ex_alu_b,
    output rv_pkg::mem_op_e       ex_mem_op,
    output rv_pkg::mem_width_e    ex_width,
    output logic [`RV_XLEN-1:0]   ex_store_data,
    output logic [`RV_REG_AW-1:0] ex_rd,
    output logic                  ex_wb_en
);

    rv_pkg::alu_op_e       alu_op_d;
    rv_pkg::mem_op_e       mem_op_d;
    rv_pkg::mem_width_e    width_d;
    logic [`RV_XLEN-1:0]   alu_a_d;
    logic [`RV_XLEN-1:0]   alu_b_d;
    logic [`RV_XLEN-1:0]   store_d;
    logic [`RV_REG_AW-1:0] rd_d;
    logic                  wb_en_d;
    logic [`RV_XLEN-1:0]   imm_i;
    logic [`RV_XLEN-1:0]   imm_s;
    logic                  f7_ok;                 // legal funct7 for an R op
    logic                  shamt_ok;              // legal upper imm bits for an I op

    // funct3 to alu op, alt is bit 30 where it matters
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            `RV_F3_ADD:  alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            `RV_F3_SLL:  alu_sel = rv_pkg::ALU_SLL;
            `RV_F3_SLT:  alu_sel = rv_pkg::ALU_SLT;
            `RV_F3_SLTU: alu_sel = rv_pkg::ALU_SLTU;
            `RV_F3_XOR:  alu_sel = rv_pkg::ALU_XOR;
            `RV_F3_SR:   alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            `RV_F3_OR:   alu_sel = rv_pkg::ALU_OR;
            default:     alu_sel = rv_pkg::ALU_AND;
        endcase
    endfunction

    assign imm_i = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};

    // SUB/SRA only take the alt funct7, everything else needs zeros
    assign f7_ok = (instr.r.funct7 == `RV_F7_BASE) ||
                   ((instr.r.funct7 == `RV_F7_ALT) &&
                    (instr.r.funct3 == `RV_F3_ADD || instr.r.funct3 == `RV_F3_SR));
    assign shamt_ok = (instr.i.funct3 != `RV_F3_SLL && instr.i.funct3 != `RV_F3_SR) ||
                      (instr.i.imm[11:5] == `RV_F7_BASE) ||
                      (instr.i.funct3 == `RV_F3_SR && instr.i.imm[11:5] == `RV_F7_ALT);

    always_comb begin
        // inactive defaults, an unknown word falls through as a bubble
        rs1_addr = '0;
        rs2_addr = '0;
        alu_op_d = rv_pkg::ALU_NOP;
        alu_a_d  = '0;
        alu_b_d  = '0;
        mem_op_d = rv_pkg::MEM_NOP;
        width_d  = rv_pkg::WORD;
        store_d  = '0;
        rd_d     = '0;
        wb_en_d  = 1'b0;

        case (instr.r.opcode)
            `RV_OP_OP: begin
                rs1_addr = instr.r.rs1;
                rs2_addr = instr.r.rs2;
                if (f7_ok) begin
                    alu_op_d = alu_sel(instr.r.funct3, instr.r.funct7[5]);
                    alu_a_d  = rs1_val;
                    alu_b_d  = rs2_val;
                    rd_d     = instr.r.rd;
                    wb_en_d  = (instr.r.rd != '0);   // x0 writes are dropped here
                end
            end
            `RV_OP_IMM: begin
                rs1_addr = instr.i.rs1;
                if (shamt_ok) begin
                    // bit 30 only selects SRAI, ADDI keeps it as immediate
                    alu_op_d = alu_sel(instr.i.funct3,
                                       (instr.i.funct3 == `RV_F3_SR) && instr.i.imm[10]);
                    alu_a_d  = rs1_val;
                    alu_b_d  = imm_i;
                    rd_d     = instr.i.rd;
                    wb_en_d  = (instr.i.rd != '0);
                end
            end
            `RV_OP_LOAD: begin
                rs1_addr = instr.i.rs1;
                if (instr.i.funct3 inside {`RV_F3_LB, `RV_F3_LH, `RV_F3_LW,
                                           `RV_F3_LBU, `RV_F3_LHU}) begin
                    alu_op_d = rv_pkg::ALU_ADD;      // address = rs1 + imm
                    alu_a_d  = rs1_val;
                    alu_b_d  = imm_i;
                    mem_op_d = rv_pkg::MEM_LOAD;
                    width_d  = rv_pkg::mem_width_e'(instr.i.funct3);
                    rd_d     = instr.i.rd;
                    wb_en_d  = (instr.i.rd != '0);
                end
            end
            `RV_OP_STORE: begin
                rs1_addr = instr.s.rs1;
                rs2_addr = instr.s.rs2;
                if (instr.s.funct3 inside {`RV_F3_SB, `RV_F3_SH, `RV_F3_SW}) begin
                    alu_op_d = rv_pkg::ALU_ADD;
                    alu_a_d  = rs1_val;
                    alu_b_d  = imm_s;
                    mem_op_d = rv_pkg::MEM_STORE;
                    width_d  = rv_pkg::mem_width_e'(instr.s.funct3);
                    store_d  = rs2_val;              // carried to the memory stage
                end
            end
            default: begin
            end
        endcase
    end

    // execute stage, control part
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_alu_op <= rv_pkg::ALU_NOP;
            ex_mem_op <= rv_pkg::MEM_NOP;
            ex_width  <= rv_pkg::WORD;
            ex_rd     <= '0;
            ex_wb_en  <= 1'b0;
        end else begin
            ex_alu_op <= alu_op_d;
            ex_mem_op <= mem_op_d;
            ex_width  <= width_d;
            ex_rd     <= rd_d;
            ex_wb_en  <= wb_en_d;
        end
    end

    // execute stage, operands
    always_ff @(posedge clk) begin
        ex_alu_a      <= alu_a_d;
        ex_alu_b      <= alu_b_d;
        ex_store_data <= store_d;
    end

endmodule

// File: hw/rv_mem_stage.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_mem_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_pkg::mem_op_e       ex_mem_op,
    input  rv_pkg::mem_width_e    ex_width,
    input  logic [`RV_XLEN-1:0]   ex_store_data,
    input  logic [`RV_REG_AW-1:0] ex_rd,
    input  logic                  ex_wb_en,
    input  logic [`RV_XLEN-1:0]   alu_out,
    output logic [`RV_REG_AW-1:0] mem_rd,
    output logic                  mem_wb_en,
    output logic                  mem_is_load,
    output logic [`RV_XLEN-1:0]   mem_alu_res,
    output logic                  wb_en,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data
);

    rv_pkg::mem_op_e        mem_op;
    rv_pkg::mem_width_e     mem_width;
    logic [`RV_XLEN-1:0]    mem_store_data;
    logic [`RV_XLEN-1:0]    dmem [0:(1 << `RV_DMEM_AW)-1];
    logic [`RV_DMEM_AW-1:0] word_addr;
    logic [1:0]             lane;               // byte within the word
    logic [`RV_XLEN-1:0]    rd_shift;
    logic [`RV_XLEN-1:0]    load_data;

    // execute-to-memory register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_op    <= rv_pkg::MEM_NOP;
            mem_width <= rv_pkg::WORD;
            mem_rd    <= '0;
            mem_wb_en <= 1'b0;
        end else begin
            mem_op    <= ex_mem_op;
            mem_width <= ex_width;
            mem_rd    <= ex_rd;
            mem_wb_en <= ex_wb_en;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_res    <= alu_out;
        mem_store_data <= ex_store_data;
    end

    assign mem_is_load = (mem_op == rv_pkg::MEM_LOAD);
    assign word_addr   = mem_alu_res[`RV_DMEM_AW+1:2];
    assign lane        = mem_alu_res[1:0];

    // store writes only its lanes
    always_ff @(posedge clk) begin
        if (mem_op == rv_pkg::MEM_STORE) begin
            case (mem_width)
                rv_pkg::BYTE_S: dmem[word_addr][{lane, 3'b000} +: 8] <= mem_store_data[7:0];
                rv_pkg::HALF_S: dmem[word_addr][{lane[1], 4'b0000} +: 16] <= mem_store_data[15:0];
                default:        dmem[word_addr] <= mem_store_data;
            endcase
        end
    end

    // load path, read is combinational so a store just before is visible
    assign rd_shift = dmem[word_addr] >> {lane, 3'b000};

    always_comb begin
        case (mem_width)
            rv_pkg::BYTE_S: load_data = {{(`RV_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            rv_pkg::HALF_S: load_data = {{(`RV_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            rv_pkg::BYTE_U: load_data = {{(`RV_XLEN-8){1'b0}}, rd_shift[7:0]};
            rv_pkg::HALF_U: load_data = {{(`RV_XLEN-16){1'b0}}, rd_shift[15:0]};
            default:        load_data = rd_shift;           // word, lane is zero
        endcase
    end

    // memory-to-write-back register, data zero when nothing is written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en   <= 1'b0;
            wb_rd   <= '0;
            wb_data <= '0;
        end else begin
            wb_en   <= mem_wb_en;
            wb_rd   <= mem_rd;
            wb_data <= !mem_wb_en ? '0 : (mem_is_load ? load_data : mem_alu_res);
        end
    end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_XLEN-1:0]   instr,      // zero word is a bubble
    output logic                  wb_en,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data
);

    // decode side
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;

    // execute stage
    rv_pkg::alu_op_e       ex_alu_op;
    logic [`RV_XLEN-1:0]   ex_alu_a;
    logic [`RV_XLEN-1:0]   ex_alu_b;
    rv_pkg::mem_op_e       ex_mem_op;
    rv_pkg::mem_width_e    ex_width;
    logic [`RV_XLEN-1:0]   ex_store_data;
    logic [`RV_REG_AW-1:0] ex_rd;
    logic                  ex_wb_en;
    logic                  ex_is_load;
    logic [`RV_XLEN-1:0]   alu_out;

    // memory stage
    logic [`RV_REG_AW-1:0] mem_rd;
    logic                  mem_wb_en;
    logic                  mem_is_load;
    logic [`RV_XLEN-1:0]   mem_alu_res;

    assign ex_is_load = (ex_mem_op == rv_pkg::MEM_LOAD);   // no alu-out forward for loads

    rv_decode i_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .ex_alu_op     (ex_alu_op),
        .ex_alu_a      (ex_alu_a),
        .ex_alu_b      (ex_alu_b),
        .ex_mem_op     (ex_mem_op),
        .ex_width      (ex_width),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_wb_en      (ex_wb_en)
    );

    rv_regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en),                 // written from the write-back stage
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    rv_forward i_forward (
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_rd       (ex_rd),
        .ex_wb_en    (ex_wb_en),
        .ex_is_load  (ex_is_load),
        .alu_out     (alu_out),
        .mem_rd      (mem_rd),
        .mem_wb_en   (mem_wb_en),
        .mem_is_load (mem_is_load),
        .mem_alu_res (mem_alu_res),
        .wb_rd       (wb_rd),
        .wb_en       (wb_en),
        .wb_data     (wb_data),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val)
    );

    rv_alu i_alu (
        .alu_op (ex_alu_op),
        .a      (ex_alu_a),
        .b      (ex_alu_b),
        .y      (alu_out)
    );

    rv_mem_stage i_mem_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_mem_op     (ex_mem_op),
        .ex_width      (ex_width),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_wb_en      (ex_wb_en),
        .alu_out       (alu_out),
        .mem_rd        (mem_rd),
        .mem_wb_en     (mem_wb_en),
        .mem_is_load   (mem_is_load),
        .mem_alu_res   (mem_alu_res),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

// File: sim/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module tb_rv_core;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] instr;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // program table with one expected write-back per entry
    logic [31:0] prog_q [$];
    logic        exp_en_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];

    logic [31:0] ref_regs [0:31];       // ISA-level register model
    logic [31:0] ref_mem [0:255];       // ISA-level data memory indexed by word
    logic [31:0] lcg_state = 32'hbc97c811;
    int          cur_entry = -1;        // table entry under check or -1 during reset

    rv_core i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    always #5 clk = ~clk;               // 10 ns period

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper lcg bits since the low ones cycle too fast
    function automatic int rand_imm();
        logic [31:0] r;
        r = lcg_next();
        return int'({{20{r[31]}}, r[31:20]});      // signed 12-bit immediate
    endfunction

    function automatic int rand_range(input int lo, input int span);
        logic [31:0] r;
        r = lcg_next();
        return lo + (int'(r[31:16]) % span);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OP_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input int rs2, input int rs1,
                                          input int imm);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), f3, v[4:0], `RV_OP_STORE};
    endfunction

    // executes one word on the model in program order
    task automatic run_ref(input logic [31:0] ins, output logic en, output logic [4:0] rd,
                           output logic [31:0] data);
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] res;
        logic        valid;
        op    = ins[6:0];
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = ref_regs[ins[19:15]];
        b     = (op == `RV_OP_IMM) ? {{20{ins[31]}}, ins[31:20]} : ref_regs[ins[24:20]];
        sh    = b[4:0];
        valid = 1'b0;
        res   = '0;
        if (op == `RV_OP_OP || op == `RV_OP_IMM) begin
            valid = 1'b1;
            case (f3)
                `RV_F3_ADD:  res = (op == `RV_OP_OP && ins[30]) ? a - b : a + b;
                `RV_F3_SLL:  res = a << sh;
                `RV_F3_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                `RV_F3_SLTU: res = {31'b0, a < b};
                `RV_F3_XOR:  res = a ^ b;
                `RV_F3_SR:   res = ins[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
                `RV_F3_OR:   res = a | b;
                default:     res = a & b;
            endcase
        end else if (op == `RV_OP_LOAD && f3 inside {`RV_F3_LB, `RV_F3_LH, `RV_F3_LW,
                                                     `RV_F3_LBU, `RV_F3_LHU}) begin
            valid = 1'b1;
            addr  = a + {{20{ins[31]}}, ins[31:20]};
            word  = ref_mem[addr[9:2]] >> {addr[1:0], 3'b000};   // lane moved to bit 0
            case (f3)
                `RV_F3_LB:  res = {{24{word[7]}}, word[7:0]};
                `RV_F3_LH:  res = {{16{word[15]}}, word[15:0]};
                `RV_F3_LBU: res = {24'b0, word[7:0]};
                `RV_F3_LHU: res = {16'b0, word[15:0]};
                default:    res = word;
            endcase
        end else if (op == `RV_OP_STORE && f3 inside {`RV_F3_SB, `RV_F3_SH, `RV_F3_SW}) begin
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            word = ref_mem[addr[9:2]];
            case (f3)
                `RV_F3_SB: word[{addr[1:0], 3'b000} +: 8] = b[7:0];
                `RV_F3_SH: word[{addr[1], 4'b0000} +: 16] = b[15:0];
                default:   word = b;
            endcase
            ref_mem[addr[9:2]] = word;
        end
        en   = valid && (rd != '0);                  // x0 and bubbles write nothing
        data = res;
        if (en)
            ref_regs[rd] = res;
    endtask

    task automatic push_entry(input logic [31:0] ins);
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
        run_ref(ins, en, rd, data);
        prog_q.push_back(ins);
        exp_en_q.push_back(en);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
    endtask

    // full 32-bit constant built from 11, 11 and 10 bit chunks without LUI
    task automatic load_const(input int rd, input logic [31:0] v);
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, rd, 0, int'(v[31:21])));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SLL, rd, rd, 11));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_OR, rd, rd, int'(v[20:10])));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SLL, rd, rd, 10));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_OR, rd, rd, int'(v[9:0])));
    endtask

    // every load width on every lane of the word at x10 + off
    task automatic lane_loads(input int off);
        int k;
        push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LW, 14, 10, off));
        for (k = 0; k < 4; k += 2) begin
            push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LH, 15, 10, off + k));
            push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LHU, 16, 10, off + k));
        end
        for (k = 0; k < 4; k++) begin
            push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LB, 17, 10, off + k));
            push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LBU, 18, 10, off + k));
        end
    endtask

    task automatic build_program();
        int         k;
        int         d;
        int         m;
        int         sel;
        int         rd;
        int         rs1;
        int         rs2;
        logic [6:0] f7;
        logic [2:0] f3;
        for (k = 0; k < 32; k++) begin
            ref_regs[k] = '0;
        end
        for (k = 0; k < 256; k++) begin
            ref_mem[k] = '0;
        end
        for (rd = 1; rd < 32; rd++)
            push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, rd, 0, rand_imm()));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5, 0, -100));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SR, 6, 5, 1024 + 3));    // srai of a negative
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SR, 7, 5, 1024 + 31));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SR, 8, 5, 4));           // srli with zero fill
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SLTU, 9, 5, -1));        // imm reads 0xffffffff
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SLTU, 9, 5, -200));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_SLT, 9, 5, -99));
        for (k = 0; k < 36; k++) begin
            sel = k % 9;                                 // funct3 is sel and 8 means srai
            rd  = rand_range(1, 31);
            rs1 = rand_range(1, 31);
            if (sel == 8)
                push_entry(enc_i(`RV_OP_IMM, `RV_F3_SR, rd, rs1, 1024 + rand_range(0, 32)));
            else if (sel == 1 || sel == 5)
                push_entry(enc_i(`RV_OP_IMM, 3'(sel), rd, rs1, rand_range(0, 32)));
            else
                push_entry(enc_i(`RV_OP_IMM, 3'(sel), rd, rs1, rand_imm()));
        end
        for (k = 0; k < 3; k++)
            push_entry(32'h0);                           // bubbles let x1..x15 settle
        // register-register ops on sources this block never writes
        for (k = 0; k < 20; k++) begin
            sel = k % 10;
            rs1 = rand_range(1, 15);
            rs2 = rand_range(1, 15);
            f7  = (sel == 1 || sel == 7) ? `RV_F7_ALT : `RV_F7_BASE;
            case (sel)
                0, 1:    f3 = `RV_F3_ADD;
                2:       f3 = `RV_F3_SLL;
                3:       f3 = `RV_F3_SLT;
                4:       f3 = `RV_F3_SLTU;
                5:       f3 = `RV_F3_XOR;
                6, 7:    f3 = `RV_F3_SR;
                8:       f3 = `RV_F3_OR;
                default: f3 = `RV_F3_AND;
            endcase
            push_entry(enc_r(f7, f3, 16 + sel, rs1, rs2));
        end
        // forwarding at distance d on rs1 (m=0), rs2 (m=1) or both (m=2)
        for (d = 1; d <= 3; d++) begin
            for (m = 0; m < 3; m++) begin
                push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 20, 0, rand_imm()));
                for (k = 1; k < d; k++)
                    push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 21 + k, 0, rand_imm()));
                rs1 = (m == 1) ? 1 : 20;
                rs2 = (m == 0) ? 2 : 20;
                f7  = (m == 2) ? `RV_F7_BASE : `RV_F7_ALT;    // sub is zero for equal sources
                push_entry(enc_r(f7, `RV_F3_ADD, 26, rs1, rs2));
            end
        end
        for (k = 0; k < 3; k++)
            push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 20, 0, rand_imm()));  // youngest wins
        push_entry(enc_r(`RV_F7_ALT, `RV_F3_ADD, 26, 20, 1));
        push_entry(enc_r(`RV_F7_BASE, `RV_F3_XOR, 27, 20, 26));
        // memory tests with base 0x100 in x10
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 10, 0, 256));
        load_const(11, 32'hf08a7c93);
        push_entry(enc_s(`RV_F3_SW, 11, 10, 0));
        lane_loads(0);                                   // first LW right behind the store
        push_entry(enc_s(`RV_F3_SW, 11, 10, -4));        // negative S immediate
        push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LW, 12, 10, -4));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 21, 0, 1));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 22, 0, 2));
        push_entry(enc_r(`RV_F7_BASE, `RV_F3_ADD, 23, 12, 12));       // load result 3 back
        lane_loads(-4);
        push_entry(enc_s(`RV_F3_SH, 11, 10, 2));
        lane_loads(0);
        load_const(13, 32'h5ac3e781);
        push_entry(enc_s(`RV_F3_SB, 11, 10, 1));
        push_entry(enc_s(`RV_F3_SB, 13, 10, 3));
        lane_loads(0);
        push_entry(enc_s(`RV_F3_SH, 13, 10, 0));
        lane_loads(0);
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 24, 0, -3));
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 25, 0, 7));
        push_entry(enc_s(`RV_F3_SW, 24, 10, 4));         // store data forwarded 2 back
        push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LW, 14, 10, 4));
        // x0, bubbles and words the pipeline drops
        push_entry(enc_i(`RV_OP_IMM, `RV_F3_ADD, 0, 0, 5));
        push_entry(enc_r(`RV_F7_BASE, `RV_F3_ADD, 0, 1, 2));
        push_entry(enc_r(`RV_F7_BASE, `RV_F3_ADD, 27, 0, 1));
        push_entry(32'h0);
        push_entry(enc_i(7'b110_1111, 3'b000, 5, 0, 16));      // jal x5
        push_entry(enc_i(7'b110_0011, 3'b000, 8, 1, 1));       // beq
        push_entry(enc_i(7'b011_0111, 3'b000, 6, 0, 291));     // lui x6
        push_entry(enc_i(`RV_OP_LOAD, 3'b011, 7, 10, 0));      // ld is not rv32i
        push_entry(enc_s(3'b011, 11, 10, 0));                  // sd must leave memory alone
        push_entry(32'h0);
        push_entry(enc_r(`RV_F7_BASE, `RV_F3_ADD, 27, 5, 0));
        push_entry(enc_r(`RV_F7_BASE, `RV_F3_ADD, 28, 6, 7));
        push_entry(enc_i(`RV_OP_LOAD, `RV_F3_LW, 14, 10, 0));
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s entry %0d: got 0x%08h, expected 0x%08h",
                     name, cur_entry, got, exp);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        int n;
        int cnt;
        instr = '0;
        build_program();
        n   = prog_q.size();
        cnt = 0;
        while (rst_n !== 1'b1) begin
            if (cnt == 50) begin
                $display("reset was not released within 50 cycles");
                $display("Checks failed");
                $fatal(1, "reset timeout");
            end
            @(negedge clk);
            check_val("wb_en", 32'(wb_en), 32'd0);      // quiet during reset
            cnt++;
        end
        // entry i goes in at this falling edge while entry i-3 is on the write-back ports
        for (int i = 0; i < n + 3; i++) begin
            @(negedge clk);
            cur_entry = i - 3;
            if (i >= 3) begin
                check_val("wb_en", 32'(wb_en), 32'(exp_en_q[i - 3]));
                if (exp_en_q[i - 3]) begin
                    check_val("wb_rd", 32'(wb_rd), 32'(exp_rd_q[i - 3]));
                    check_val("wb_data", wb_data, exp_data_q[i - 3]);
                end
            end else begin
                check_val("wb_en", 32'(wb_en), 32'd0);  // pipeline still empty
            end
            instr = (i < n) ? prog_q[i] : '0;
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_forward.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_mem_stage.sv
hw/rv_core.sv
sim/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator, exit status reflects the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f tb.f --top-module tb_rv_core \
    -Mdir obj_dir -o tb_rv_core > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
